// File: rtl/gearbox_pkg.sv
// shared byte width, controller state type and default sizes for the tx gearbox, used by scoped name
package gearbox_pkg;

  // one byte lane of the sample and link words
  localparam int BYTE_W = 8;

  // default geometry of the gearbox, picked up by the top level parameters
  localparam int DEF_IN_BYTES    = 6;   // bytes per framer word
  localparam int DEF_OUT_BYTES   = 4;   // bytes per link word
  localparam int DEF_DEPTH       = 16;  // words in the buffer
  localparam int DEF_START_LEVEL = 4;   // fill level at which streaming starts

  // controller states
  // IDLE waits for the link, ALIGN waits for the multiframe edge,
  // FILL collects words up to the start level and RUN streams to the link
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ALIGN = 2'd1,
    FILL  = 2'd2,
    RUN   = 2'd3
  } gearbox_state_e;

endpackage

// File: rtl/gearbox_ctrl.sv
// gearbox controller: tracks link alignment and buffer fill, grants buffer reads/writes and flags faults
module gearbox_ctrl #(
  parameter int DEPTH       = gearbox_pkg::DEF_DEPTH,
  parameter int START_LEVEL = gearbox_pkg::DEF_START_LEVEL
) (
  input  logic                     link_clk,
  input  logic                     addr_reset,
  input  logic                     in_valid,
  input  logic                     lmfc_edge,
  input  logic                     out_ready,
  input  logic                     word_req,
  input  logic [$clog2(DEPTH):0]   level,
  output logic                     wr_en,
  output logic                     rd_en,
  output logic                     flush,
  output logic                     run,
  output logic                     underflow,
  output logic                     overflow
);

  localparam int LVL_W = $clog2(DEPTH) + 1;

  gearbox_pkg::gearbox_state_e state, state_next;

  logic active;     // buffer accepts input words
  logic full;
  logic empty;
  logic link_drop;  // out_ready went away while the link was in use
  logic fault;

  assign full  = (level == LVL_W'(DEPTH));
  assign empty = (level == '0);

  assign active    = (state == gearbox_pkg::FILL) || (state == gearbox_pkg::RUN);
  assign link_drop = (state != gearbox_pkg::IDLE) && !out_ready;

  // the only full and empty tests of the gearbox live here
  assign overflow  = active && out_ready && in_valid && full;
  assign underflow = (state == gearbox_pkg::RUN) && out_ready && word_req && empty;
  assign fault     = overflow || underflow;

  assign wr_en = active && out_ready && in_valid && !full;
  assign rd_en = word_req && !empty;  // word_req only comes while run is high
  assign run   = (state == gearbox_pkg::RUN);

  // an edge seen without the link also restarts the pointers, like a fault or a link drop
  assign flush = fault || link_drop || (lmfc_edge && !out_ready);

  always_comb begin
    state_next = state;
    case (state)
      gearbox_pkg::IDLE: begin
        if (out_ready) state_next = gearbox_pkg::ALIGN;
      end
      gearbox_pkg::ALIGN: begin
        if (!out_ready) begin
          state_next = gearbox_pkg::IDLE;
        end else if (lmfc_edge) begin
          state_next = gearbox_pkg::FILL;  // words count from the next cycle on
        end
      end
      gearbox_pkg::FILL: begin
        if (!out_ready) begin
          state_next = gearbox_pkg::IDLE;
        end else if (fault) begin
          state_next = gearbox_pkg::ALIGN;
        end else if (level >= LVL_W'(START_LEVEL)) begin
          state_next = gearbox_pkg::RUN;
        end
      end
      gearbox_pkg::RUN: begin
        if (!out_ready) begin
          state_next = gearbox_pkg::IDLE;
        end else if (fault) begin
          state_next = gearbox_pkg::ALIGN;  // realign on the next multiframe edge
        end
      end
      default: state_next = gearbox_pkg::IDLE;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (addr_reset) begin
      state <= gearbox_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: rtl/gearbox_buffer.sv
// word buffer between the framer and the unpacker, circular memory with a registered read port
module gearbox_buffer #(
  parameter int IN_BYTES  = gearbox_pkg::DEF_IN_BYTES,
  parameter int OUT_BYTES = gearbox_pkg::DEF_OUT_BYTES,
  parameter int DEPTH     = gearbox_pkg::DEF_DEPTH
) (
  input  logic                                    link_clk,
  input  logic                                    addr_reset,
  input  logic                                    wr_en,
  input  logic                                    rd_en,
  input  logic                                    flush,
  input  logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0] wr_data,
  output logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0] rd_data,
  output logic [$clog2(DEPTH):0]                  level
);

  localparam int WORD_W = IN_BYTES * gearbox_pkg::BYTE_W;
  localparam int ADDR_W = $clog2(DEPTH);

  // each entry holds a whole framer word, so a link word never spans more than two entries
  if (OUT_BYTES > IN_BYTES) begin : g_width_check
    $error("gearbox_buffer only supports OUT_BYTES <= IN_BYTES");
  end

  logic [WORD_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W-1:0] wr_ptr_inc;
  logic [ADDR_W-1:0] rd_ptr_inc;

  // pointers wrap at DEPTH, which need not be a power of two
  assign wr_ptr_inc = (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_inc = (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  always_ff @(posedge link_clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge link_clk) begin
    if (rd_en) rd_data <= mem[rd_ptr];  // valid one cycle after rd_en
  end

  always_ff @(posedge link_clk) begin
    if (addr_reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr_inc;
      if (rd_en) rd_ptr <= rd_ptr_inc;
      // the controller never reads empty or writes full, so level stays in range
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

// File: rtl/byte_unpacker.sv
// slices buffered framer words into link words through a byte residue register, requesting words as needed
module byte_unpacker #(
  parameter int IN_BYTES  = gearbox_pkg::DEF_IN_BYTES,
  parameter int OUT_BYTES = gearbox_pkg::DEF_OUT_BYTES,
  parameter int DEPTH     = gearbox_pkg::DEF_DEPTH
) (
  input  logic                                     link_clk,
  input  logic                                     addr_reset,
  input  logic                                     run,
  input  logic                                     flush,
  input  logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0]  rd_data,
  output logic                                     word_req,
  output logic [OUT_BYTES*gearbox_pkg::BYTE_W-1:0] link_data,
  output logic                                     link_valid
);

  localparam int OUT_W     = OUT_BYTES * gearbox_pkg::BYTE_W;
  localparam int RES_BYTES = IN_BYTES + OUT_BYTES;
  localparam int RES_W     = RES_BYTES * gearbox_pkg::BYTE_W;
  localparam int CNT_W     = $clog2(RES_BYTES + 1);

  localparam logic [CNT_W-1:0] IN_CNT  = CNT_W'(IN_BYTES);
  localparam logic [CNT_W-1:0] OUT_CNT = CNT_W'(OUT_BYTES);

  // a request needs one word buffered and one in flight behind it to keep streaming
  if (DEPTH < 2) begin : g_depth_check
    $error("byte_unpacker needs a buffer of at least two words");
  end

  logic [RES_W-1:0] res_q;
  logic [RES_W-1:0] res_shift;
  logic [RES_W-1:0] res_d;
  logic [RES_W-1:0] keep_mask;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_shift;
  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] rem_next;
  logic             pend_q;  // read data arrives this cycle
  logic             emit;

  assign emit = run && (cnt_q >= OUT_CNT);

  always_comb begin
    res_shift = emit ? (res_q >> OUT_W) : res_q;  // oldest bytes sit at the bottom
    cnt_shift = emit ? (cnt_q - OUT_CNT) : cnt_q;
    keep_mask = ~({RES_W{1'b1}} << (cnt_shift * gearbox_pkg::BYTE_W));
    res_d     = res_shift;
    cnt_d     = cnt_shift;
    if (pend_q) begin
      // append the new word right above the bytes still held
      res_d = (res_shift & keep_mask) | (RES_W'(rd_data) << (cnt_shift * gearbox_pkg::BYTE_W));
      cnt_d = cnt_shift + IN_CNT;
    end
  end

  // bytes left once next cycle's link word has gone out
  assign rem_next = (cnt_d >= OUT_CNT) ? (cnt_d - OUT_CNT) : cnt_d;
  assign word_req = run && (rem_next < OUT_CNT);

  assign link_data  = res_q[OUT_W-1:0];
  assign link_valid = emit && !flush;  // nothing leaves in a fault or link drop cycle

  always_ff @(posedge link_clk) begin
    if (addr_reset || flush || !run) begin
      cnt_q  <= '0;
      pend_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      pend_q <= word_req;  // an unserved request is an underflow and flushes instead
    end
  end

  always_ff @(posedge link_clk) begin
    res_q <= res_d;
  end

endmodule

// File: rtl/tx_gearbox_top.sv
// tx gearbox top level: wires controller, word buffer and unpacker together and sets their sizes
module tx_gearbox_top #(
  parameter int IN_BYTES    = gearbox_pkg::DEF_IN_BYTES,
  parameter int OUT_BYTES   = gearbox_pkg::DEF_OUT_BYTES,
  parameter int DEPTH       = gearbox_pkg::DEF_DEPTH,
  parameter int START_LEVEL = gearbox_pkg::DEF_START_LEVEL
) (
  input  logic                                     link_clk,
  input  logic                                     addr_reset,
  input  logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0]  in_data,
  input  logic                                     in_valid,
  input  logic                                     lmfc_edge,
  input  logic                                     out_ready,
  output logic [OUT_BYTES*gearbox_pkg::BYTE_W-1:0] link_data,
  output logic                                     link_valid,
  output logic                                     underflow,
  output logic                                     overflow
);

  logic                                    wr_en;
  logic                                    rd_en;
  logic                                    flush;
  logic                                    run;
  logic                                    word_req;
  logic [$clog2(DEPTH):0]                  level;
  logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0] rd_data;

  gearbox_ctrl #(
    .DEPTH       (DEPTH),
    .START_LEVEL (START_LEVEL)
  ) u_ctrl (
    .link_clk   (link_clk),
    .addr_reset (addr_reset),
    .in_valid   (in_valid),
    .lmfc_edge  (lmfc_edge),
    .out_ready  (out_ready),
    .word_req   (word_req),
    .level      (level),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .flush      (flush),
    .run        (run),
    .underflow  (underflow),
    .overflow   (overflow)
  );

  gearbox_buffer #(
    .IN_BYTES  (IN_BYTES),
    .OUT_BYTES (OUT_BYTES),
    .DEPTH     (DEPTH)
  ) u_buf (
    .link_clk   (link_clk),
    .addr_reset (addr_reset),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .flush      (flush),
    .wr_data    (in_data),
    .rd_data    (rd_data),
    .level      (level)
  );

  byte_unpacker #(
    .IN_BYTES  (IN_BYTES),
    .OUT_BYTES (OUT_BYTES),
    .DEPTH     (DEPTH)
  ) u_unpack (
    .link_clk   (link_clk),
    .addr_reset (addr_reset),
    .run        (run),
    .flush      (flush),
    .rd_data    (rd_data),
    .word_req   (word_req),
    .link_data  (link_data),
    .link_valid (link_valid)
  );

endmodule

// File: dv/gearbox_properties.sv
// concurrent checks on the tx gearbox top level, attached to it by bind from the testbench
module gearbox_properties #(
  parameter int DEPTH = gearbox_pkg::DEF_DEPTH
) (
  input logic                        link_clk,
  input logic                        addr_reset,
  input logic                        out_ready,
  input logic                        link_valid,
  input logic                        underflow,
  input logic                        overflow,
  input logic                        rd_en,
  input logic [$clog2(DEPTH):0]      level,
  input gearbox_pkg::gearbox_state_e state
);
  timeunit 1ns;
  timeprecision 100ps;

  // a fault cycle flushes the unpacker, so nothing may leave with it
  a_no_valid_on_fault: assert property (@(posedge link_clk) disable iff (addr_reset)
    !(link_valid && (underflow || overflow))) else $error("link_valid high in a fault cycle");

  a_single_fault: assert property (@(posedge link_clk) disable iff (addr_reset)
    !(underflow && overflow)) else $error("underflow and overflow high together");

  a_idle_needs_link: assert property (@(posedge link_clk) disable iff (addr_reset)
    (state == gearbox_pkg::IDLE && !out_ready) |=> (state == gearbox_pkg::IDLE))
    else $error("state left IDLE without out_ready");

  a_no_empty_read: assert property (@(posedge link_clk) disable iff (addr_reset)
    !(rd_en && level == '0)) else $error("rd_en raised on an empty buffer");

endmodule

// File: dv/gearbox_monitor.sv
// checker for the tx gearbox: rebuilds the byte stream from the DUT ports and compares each link word
module gearbox_monitor #(
  parameter int IN_BYTES  = gearbox_pkg::DEF_IN_BYTES,
  parameter int OUT_BYTES = gearbox_pkg::DEF_OUT_BYTES
) (
  input logic                                     link_clk,
  input logic                                     addr_reset,
  input logic [IN_BYTES*gearbox_pkg::BYTE_W-1:0]  in_data,
  input logic                                     in_valid,
  input logic                                     lmfc_edge,
  input logic                                     out_ready,
  input logic [OUT_BYTES*gearbox_pkg::BYTE_W-1:0] link_data,
  input logic                                     link_valid,
  input logic                                     underflow,
  input logic                                     overflow
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BW    = gearbox_pkg::BYTE_W;
  localparam int OUT_W = OUT_BYTES * BW;

  logic [BW-1:0] byte_q[$];  // bytes accepted since the last alignment, oldest first
  int   mode = 0;            // 0 link down, 1 waiting for the edge, 2 capturing
  logic streaming = 1'b0;
  int   mismatch_count = 0;
  int   protocol_count = 0;
  int   word_count = 0;
  int   fault_count = 0;

  // takes the next link word out of the byte stream, byte 0 in the low bits
  function automatic logic [OUT_W-1:0] expected_link_word(output bit short);
    logic [OUT_W-1:0] w;
    int i;
    w = '0;
    short = (byte_q.size() < OUT_BYTES);
    if (!short) begin
      for (i = 0; i < OUT_BYTES; i++) w[i*BW +: BW] = byte_q.pop_front();
    end
    return w;
  endfunction

  always @(posedge link_clk) begin
    logic [OUT_W-1:0] exp_word;
    bit short;
    int i;
    if (addr_reset) begin
      byte_q.delete();
      mode = 0;
      streaming = 1'b0;
    end else begin
      if (link_valid && mode != 2) begin
        $display("link_valid seen while the gearbox is not aligned");
        protocol_count++;
      end else if (link_valid) begin
        exp_word = expected_link_word(short);
        word_count++;
        if (short) begin
          $display("link word sent before enough input bytes were accepted");
          protocol_count++;
        end else if (link_data !== exp_word) begin
          $display("error: link_data 0x%h, expected 0x%h", link_data, exp_word);
          mismatch_count++;
        end
      end else if (streaming && !(underflow || overflow || !out_ready)) begin
        $display("link_valid dropped without a fault or a link drop");
        protocol_count++;
      end
      streaming = link_valid;
      if (underflow || overflow) fault_count++;
      case (mode)
        0: if (out_ready) mode = 1;
        1: begin
          if (!out_ready) mode = 0;
          else if (lmfc_edge) begin
            mode = 2;  // words count from the next cycle on
            byte_q.delete();
          end
        end
        default: begin
          if (!out_ready || underflow || overflow) begin
            mode = out_ready ? 1 : 0;
            byte_q.delete();
          end else if (in_valid) begin
            for (i = 0; i < IN_BYTES; i++) byte_q.push_back(in_data[i*BW +: BW]);
          end
        end
      endcase
    end
  end

endmodule

// File: dv/tb_top.sv
// top of the testbench that runs the tx gearbox through its stream, fault and link drop phases
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IN_W  = gearbox_pkg::DEF_IN_BYTES * gearbox_pkg::BYTE_W;
  localparam int OUT_W = gearbox_pkg::DEF_OUT_BYTES * gearbox_pkg::BYTE_W;

  logic             link_clk;
  logic             addr_reset;
  logic [IN_W-1:0]  in_data = '0;
  logic             in_valid = 1'b0;
  logic             lmfc_edge = 1'b0;
  logic             out_ready;
  logic [OUT_W-1:0] link_data;
  logic             link_valid;
  logic             underflow;
  logic             overflow;

  int seed = 8984;
  int cyc = 0;
  int in_mode = 0;  // 0 no input, 1 two words in three cycles, 2 a word every cycle
  int phase_errors = 0;

  initial begin
    link_clk = 1'b0;
    forever #10 link_clk = ~link_clk;
  end

  function automatic logic [IN_W-1:0] random_word();
    logic [IN_W-1:0] w;
    logic [31:0] r;
    int i;
    for (i = 0; i < gearbox_pkg::DEF_IN_BYTES; i++) begin
      r = $random(seed);
      w[i*gearbox_pkg::BYTE_W +: gearbox_pkg::BYTE_W] = r[gearbox_pkg::BYTE_W-1:0];
    end
    return w;
  endfunction

  always @(posedge link_clk) begin
    cyc       <= cyc + 1;
    lmfc_edge <= (cyc % 32 == 31);  // one multiframe every 32 cycles
    in_valid  <= (in_mode == 2) || (in_mode == 1 && cyc % 3 != 0);
    in_data   <= random_word();
  end

  // sel 0 waits for link_valid, 1 for underflow, 2 for overflow
  task automatic wait_event(input int sel, input int limit, input string what);
    int n;
    bit hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < limit) begin
      @(posedge link_clk);
      hit = (sel == 0) ? link_valid : (sel == 1) ? underflow : overflow;
      n++;
    end
    if (!hit) begin
      $display("timeout: no %s within %0d cycles", what, limit);
      phase_errors++;
    end
  endtask

  tx_gearbox_top dut0 (.*);

  gearbox_monitor mon0 (.*);

  bind tx_gearbox_top gearbox_properties #(.DEPTH(DEPTH)) props0 (
    .link_clk, .addr_reset, .out_ready, .link_valid, .underflow, .overflow,
    .rd_en, .level, .state(u_ctrl.state)
  );

  initial begin
    int faults_before;
    int total;
    addr_reset = 1'b1;
    out_ready  = 1'b0;
    repeat (2) @(posedge link_clk);
    addr_reset <= 1'b0;
    in_mode    <= 1;
    repeat (40) @(posedge link_clk);  // framer runs while the link is still down
    out_ready <= 1'b1;
    wait_event(0, 120, "link_valid after the link came up");
    @(negedge link_clk);
    faults_before = mon0.fault_count;
    repeat (300) @(posedge link_clk);
    @(negedge link_clk);
    if (mon0.fault_count != faults_before) begin
      $display("a fault appeared during the balanced stream");
      phase_errors++;
    end
    in_mode <= 0;
    wait_event(1, 60, "underflow after the input stopped");
    in_mode <= 1;
    wait_event(0, 120, "link_valid after the underflow");
    repeat (100) @(posedge link_clk);
    in_mode <= 2;
    wait_event(2, 200, "overflow with a word every cycle");
    in_mode <= 1;
    wait_event(0, 120, "link_valid after the overflow");
    repeat (100) @(posedge link_clk);
    out_ready <= 1'b0;
    repeat (20) @(posedge link_clk);
    out_ready <= 1'b1;
    wait_event(0, 120, "link_valid after the link drop");
    repeat (100) @(posedge link_clk);
    @(negedge link_clk);
    total = mon0.mismatch_count + mon0.protocol_count + phase_errors;
    $display("checked %0d link words: %0d mismatches, %0d protocol errors, %0d phase errors",
             mon0.word_count, mon0.mismatch_count, mon0.protocol_count, phase_errors);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/gearbox_pkg.sv
rtl/gearbox_ctrl.sv
rtl/gearbox_buffer.sv
rtl/byte_unpacker.sv
rtl/tx_gearbox_top.sv
dv/gearbox_properties.sv
dv/gearbox_monitor.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the gearbox testbench with Verilator, runs it and judges the result from the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_top -f sources.f -Mdir obj_dir -o tb_top_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
